//--- compile.f
verilog/rv_isa_pkg.sv
verilog/idu_ctrl_pkg.sv
verilog/idu_decoder.sv
verilog/idu_hazard_fwd.sv
verilog/idu_branch_unit.sv
verilog/idu_issue_ctrl.sv
verilog/idu_top.sv
verification/idu_checker.sv
verification/tb_top.sv

//--- verification/idu_checker.sv
// decode stage checker with reference decode, operand model and issue comparisons
`timescale 1ns/1ps

module idu_checker import rv_isa_pkg::*, idu_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  instr_u      instr_i,
  input  word_t       pc_i,
  input  logic        in_valid_i,
  input  logic        in_ready_i,
  input  logic        out_valid_i,
  input  logic        out_ready_i,
  input  logic        pc_write_i,
  input  issue_t      issue_i,
  input  exu_status_t exu_i,
  input  lsu_status_t lsu_i,
  input  wbu_status_t wbu_i,
  output int          errors_o,
  output int          xfers_o
);

  word_t       sent_instr[$];
  word_t       sent_pc[$];
  exu_status_t exu_snap;
  lsu_status_t lsu_snap;
  wbu_status_t wbu_snap;
  reg_idx_t    rd_snap;
  reg_idx_t    last_rd;
  issue_t      prev_issue;
  logic        prev_wait;
  issue_t      want;
  word_t       w_front;
  word_t       pc_front;
  reg_idx_t    s1;
  reg_idx_t    s2;
  logic        owed;
  int          errors;
  int          xfers;

  assign errors_o = errors;
  assign xfers_o  = xfers;

  task automatic report_error(string msg);
    errors++;
    $display("CHECK FAILED @%0t: %s", $time, msg);
  endtask

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp_val);
    if (got !== exp_val)
      report_error($sformatf("%s got %0h expected %0h", name, got, exp_val));
  endtask

  // U and J formats have no rs1
  function automatic reg_idx_t rs1_of(word_t w);
    return (w[6:0] inside {OP_LUI, OP_AUIPC, OP_JAL}) ? 5'd0 : w[19:15];
  endfunction

  // only R, S and B read rs2
  function automatic reg_idx_t rs2_of(word_t w);
    return (w[6:0] inside {OP_OP, OP_STORE, OP_BRANCH}) ? w[24:20] : 5'd0;
  endfunction

  function automatic logic src_match(reg_idx_t a, reg_idx_t b, reg_idx_t rd);
    return (rd != 0) && (a == rd || b == rd);
  endfunction

  // newest value seen at the load edge
  function automatic word_t operand(reg_idx_t idx);
    if (idx == 0)
      return '0;
    if (exu_snap.busy && exu_snap.writes_reg && idx == rd_snap)
      return exu_snap.result;
    if (wbu_snap.reg_valid && idx == wbu_snap.rd)
      return wbu_snap.wd;
    return idx * 32'h0100_4d13;
  endfunction

  function automatic issue_t ref_decode(word_t w, word_t pc);
    issue_t     r;
    logic [6:0] op;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    logic       lt;
    logic       taken;
    op = w[6:0];
    f3 = w[14:12];
    a  = operand(rs1_of(w));
    b  = operand(rs2_of(w));
    r  = '0;
    r.instr  = w;
    r.pc     = pc;
    r.reg_en = !(op inside {OP_STORE, OP_BRANCH});
    r.rd     = r.reg_en ? w[11:7] : 5'd0;
    case (op)
      OP_LUI, OP_AUIPC: r.imm = {w[31:12], 12'b0};
      OP_JAL:    r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      OP_BRANCH: r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      OP_STORE:  r.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      OP_OP:     r.imm = '0;
      default:   r.imm = {{20{w[31]}}, w[31:20]};
    endcase
    r.alu_op = ALU_ADD;
    if (op == OP_LUI)
      r.alu_op = ALU_IMM;
    else if (op == OP_BRANCH)
      r.alu_op = (f3[2:1] == 2'b00) ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
    else if (op == OP_IMM || op == OP_OP) begin
      case (f3)
        3'd0: r.alu_op = (op == OP_OP && w[30]) ? ALU_SUB : ALU_ADD;
        3'd1: r.alu_op = ALU_SLL;
        3'd2: r.alu_op = ALU_SLT;
        3'd3: r.alu_op = ALU_SLTU;
        3'd4: r.alu_op = ALU_XOR;
        3'd5: r.alu_op = w[30] ? ALU_SRA : ALU_SRL;
        3'd6: r.alu_op = ALU_OR;
        default: r.alu_op = ALU_AND;
      endcase
    end
    if (op == OP_LOAD) begin
      r.mem.ren   = 1'b1;
      r.mem.sign  = (f3 == 3'd0 || f3 == 3'd1);
      r.mem.rmask = f3[1] ? 32'hffff_ffff : (f3[0] ? 32'h0000_ffff : 32'h0000_00ff);
    end
    if (op == OP_STORE) begin
      r.mem.wen   = 1'b1;
      r.mem.wmask = (8'd1 << (4'd1 << f3[1:0])) - 8'd1;
    end
    r.branch = (op == OP_BRANCH);
    r.br_op  = r.branch ? f3 : 3'd0;
    if (op == OP_JAL || op == OP_JALR)
      r.wd_sel = WD_PC4;
    else if (op == OP_LOAD)
      r.wd_sel = WD_LOAD;
    if (op == OP_JAL || op == OP_BRANCH)
      r.pc_sel = PC_REL;
    else if (op == OP_JALR)
      r.pc_sel = PC_REG;
    r.src1       = (op inside {OP_AUIPC, OP_JAL}) ? pc : a;
    r.src2       = (op inside {OP_OP, OP_BRANCH}) ? b : r.imm;
    r.store_data = b;
    lt    = f3[1] ? (a < b) : ($signed(a) < $signed(b));
    taken = f3[2] ? (lt ^ f3[0]) : ((a == b) ^ f3[0]);
    if (op == OP_JAL || (op == OP_BRANCH && taken))
      r.pc_next = pc + r.imm;
    else if (op == OP_JALR)
      r.pc_next = (a + r.imm) & ~32'd1;
    else
      r.pc_next = pc + 32'd4;
    return r;
  endfunction

  initial begin
    errors = 0;
    xfers  = 0;
  end

  always @(posedge clk) begin
    if (rst) begin
      last_rd   = '0;
      prev_wait = 1'b0;
    end else begin
      // two outstanding means one of them sits in the buffer
      if (sent_instr.size() == 2 && in_ready_i)
        report_error("in_ready_o high while the buffer is full");
      if (prev_wait && issue_i !== prev_issue)
        report_error("issue_o changed while waiting for out_ready_i");
      check_val("pc_write", pc_write_i, out_valid_i && out_ready_i);
      if (out_valid_i && out_ready_i) begin
        xfers++;
        if (sent_instr.size() == 0) begin
          report_error("transfer with no instruction outstanding");
        end else begin
          w_front  = sent_instr.pop_front();
          pc_front = sent_pc.pop_front();
          want     = ref_decode(w_front, pc_front);
          s1       = rs1_of(w_front);
          s2       = rs2_of(w_front);
          owed = (exu_snap.starting && exu_snap.writes_reg && src_match(s1, s2, rd_snap)) ||
                 (lsu_snap.busy && src_match(s1, s2, lsu_snap.rd));
          if (owed)
            report_error("issued while a source register was still owed");
          check_val("instr", issue_i.instr, want.instr);
          check_val("pc", issue_i.pc, want.pc);
          check_val("rd", issue_i.rd, want.rd);
          check_val("imm", issue_i.imm, want.imm);
          check_val("alu_op", issue_i.alu_op, want.alu_op);
          check_val("wd_sel", issue_i.wd_sel, want.wd_sel);
          check_val("pc_sel", issue_i.pc_sel, want.pc_sel);
          check_val("br_op", issue_i.br_op, want.br_op);
          check_val("branch", issue_i.branch, want.branch);
          check_val("mem", issue_i.mem, want.mem);
          check_val("reg_en", issue_i.reg_en, want.reg_en);
          check_val("src1", issue_i.src1, want.src1);
          check_val("src2", issue_i.src2, want.src2);
          check_val("store_data", issue_i.store_data, want.store_data);
          check_val("pc_next", issue_i.pc_next, want.pc_next);
          last_rd = want.rd;
        end
      end
      if (in_valid_i) begin
        sent_instr.push_back(instr_i.word);
        sent_pc.push_back(pc_i);
      end
      if (sent_instr.size() > 2)
        report_error("more than two instructions held in the decode stage");
      // last edge with out_valid low is the load edge
      if (!out_valid_i) begin
        exu_snap = exu_i;
        lsu_snap = lsu_i;
        wbu_snap = wbu_i;
        rd_snap  = last_rd;
      end
      prev_wait  = out_valid_i && !out_ready_i;
      prev_issue = issue_i;
    end
  end

endmodule

//--- verification/tb_top.sv
// testbench top with clock, reset, fetch and later-stage models, DUT and run limit
`timescale 1ns/1ps

module tb_top import rv_isa_pkg::*, idu_ctrl_pkg::*; ();

  localparam int N_INSTR    = 600;
  localparam int MAX_CYCLES = N_INSTR * 12 + 16;

  logic        clk;
  logic        rst;
  instr_u      instr;
  word_t       pc;
  logic        in_valid;
  logic        in_ready;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  word_t       rs1_data;
  word_t       rs2_data;
  exu_status_t exu;
  lsu_status_t lsu;
  wbu_status_t wbu;
  logic        out_valid;
  logic        out_ready;
  issue_t      issue;
  logic        pc_write;
  int          chk_errors;
  int          chk_xfers;
  logic [31:0] rng;
  logic [31:0] r;
  logic [31:0] v;
  logic        xfer;
  int          sent;
  int          xfers;
  int          exu_left;
  int          phase;
  int          cycles;

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] random_instr();
    logic [31:0] s;
    logic [31:0] w;
    logic [2:0]  f3;
    s = next_random();
    w = next_random();
    // registers x0..x7 only so dependencies are frequent
    w[11:7]  = {2'b00, s[2:0]};
    w[19:15] = {2'b00, s[5:3]};
    w[24:20] = {2'b00, s[8:6]};
    f3 = s[11:9];
    case (s[15:12] % 9)
      0: w[6:0] = OP_LUI;
      1: w[6:0] = OP_AUIPC;
      2: w[6:0] = OP_JAL;
      3: {w[14:12], w[6:0]} = {3'd0, OP_JALR};
      4: {w[14:12], w[6:0]} = {(f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3, OP_BRANCH};
      5: {w[14:12], w[6:0]} = {f3 == 3'd3 ? 3'd2 : (f3 > 3'd5 ? f3 - 3'd2 : f3), OP_LOAD};
      6: {w[14:12], w[6:0]} = {3'(f3 % 3), OP_STORE};
      7: begin
        {w[14:12], w[6:0]} = {f3, OP_IMM};
        if (f3 == 3'd1 || f3 == 3'd5)
          w[31:25] = {1'b0, s[16] && f3 == 3'd5, 5'b0};
      end
      default: begin
        {w[14:12], w[6:0]} = {f3, OP_OP};
        w[31:25] = {1'b0, s[16] && (f3 == 3'd0 || f3 == 3'd5), 5'b0};
      end
    endcase
    return w;
  endfunction

  // register file read with x0 reading zero
  assign rs1_data = rs1 * 32'h0100_4d13;
  assign rs2_data = rs2 * 32'h0100_4d13;

  idu_top dut (
    .clk(clk), .rst(rst), .instr_i(instr), .pc_i(pc), .in_valid_i(in_valid),
    .in_ready_o(in_ready), .rs1_o(rs1), .rs2_o(rs2), .rs1_data_i(rs1_data),
    .rs2_data_i(rs2_data), .exu_i(exu), .lsu_i(lsu), .wbu_i(wbu),
    .out_valid_o(out_valid), .out_ready_i(out_ready), .issue_o(issue), .pc_write_o(pc_write)
  );

  idu_checker u_checker (
    .clk(clk), .rst(rst), .instr_i(instr), .pc_i(pc), .in_valid_i(in_valid),
    .in_ready_i(in_ready), .out_valid_i(out_valid), .out_ready_i(out_ready),
    .pc_write_i(pc_write), .issue_i(issue), .exu_i(exu), .lsu_i(lsu), .wbu_i(wbu),
    .errors_o(chk_errors), .xfers_o(chk_xfers)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rng       = 32'h0958cd7c;
    rst       = 1'b1;
    instr     = '0;
    pc        = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    exu       = '0;
    lsu       = '0;
    wbu       = '0;
    sent      = 0;
    xfers     = 0;
    exu_left  = 0;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    while (xfers < N_INSTR) begin
      @(posedge clk);
      xfer = out_valid && out_ready;
      if (xfer)
        xfers++;
      #1;
      // execute model starts on the first busy cycle
      if (xfer) begin
        exu.result     = issue.src1 + issue.src2;
        exu.writes_reg = issue.reg_en;
        exu_left       = 1 + next_random() % 3;
        exu.starting   = 1'b1;
      end else begin
        exu.starting = 1'b0;
        if (exu_left > 0)
          exu_left--;
      end
      exu.busy = exu_left > 0;
      r = next_random();
      out_ready = !exu.busy && (r[1:0] != 2'b00);
      // phase 0 plain, phase 1 adds write-back, phase 2 adds loads in flight
      phase = xfers / 200;
      wbu.reg_valid = phase >= 1 && r[2];
      wbu.rd        = {2'b00, r[5:3]};
      wbu.wd        = next_random();
      lsu.busy      = phase == 2 && r[9:8] == 2'b00;
      lsu.rd        = {2'b00, r[12:10]};
      // fetch waits for pc_next unless the result is already waiting
      in_valid = 1'b0;
      if (sent < N_INSTR && in_ready && r[13] && (sent == xfers || out_valid)) begin
        in_valid    = 1'b1;
        instr.word  = random_instr();
        v           = next_random();
        pc          = {v[31:2], 2'b00};
        sent++;
      end
    end
    repeat (4) @(posedge clk);
    $display("transfers %0d of %0d, errors %0d", chk_xfers, N_INSTR, chk_errors);
    if (chk_errors == 0 && chk_xfers == N_INSTR) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, only %0d of %0d instructions issued",
             cycles, xfers, N_INSTR);
    $display("Errors found");
    $finish;
  end

endmodule

//--- verilog/idu_branch_unit.sv
// branch unit: condition compare and next pc selection
`timescale 1ns/1ps

module idu_branch_unit import rv_isa_pkg::*, idu_ctrl_pkg::*; (
  input  word_t     pc_i,
  input  word_t     imm_i,
  input  word_t     src1_i,
  input  word_t     src2_i,
  input  dec_ctrl_t ctrl_i,
  output word_t     pc_next_o
);

  logic  eq;
  logic  lt;
  logic  ltu;
  logic  taken;
  word_t pc_seq;
  word_t jalr_sum;

  assign eq  = (src1_i == src2_i);
  assign lt  = ($signed(src1_i) < $signed(src2_i));
  assign ltu = (src1_i < src2_i);

  always_comb begin
    case (ctrl_i.br_op)
      F3_BEQ:  taken = eq;
      F3_BNE:  taken = !eq;
      F3_BLT:  taken = lt;
      F3_BGE:  taken = !lt;
      F3_BLTU: taken = ltu;
      F3_BGEU: taken = !ltu;
      default: taken = 1'b0;
    endcase
  end

  assign pc_seq   = pc_i + 32'd4;
  assign jalr_sum = src1_i + imm_i;

  // jal always takes the pc-relative target
  always_comb begin
    case (ctrl_i.pc_sel)
      PC_REL:  pc_next_o = (!ctrl_i.branch || taken) ? pc_i + imm_i : pc_seq;
      PC_REG:  pc_next_o = {jalr_sum[31:1], 1'b0};
      default: pc_next_o = pc_seq;
    endcase
  end

endmodule

//--- verilog/idu_ctrl_pkg.sv
// decode stage control package: ALU ops, selects, control and issue bundles, stage status
package idu_ctrl_pkg;

  import rv_isa_pkg::*;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_IMM
  } alu_op_e;

  typedef enum logic {SRC1_REG, SRC1_PC} src1_sel_e;
  typedef enum logic {SRC2_REG, SRC2_IMM} src2_sel_e;

  typedef enum logic [1:0] {WD_ALU, WD_LOAD, WD_PC4} wd_sel_e;

  typedef enum logic [1:0] {PC_SEQ, PC_REL, PC_REG} pc_sel_e;

  typedef struct packed {
    logic       ren;
    logic       wen;
    logic [7:0] wmask;
    word_t      rmask;
    logic       sign;
  } mem_ctrl_t;

  typedef struct packed {
    alu_op_e    alu_op;
    src1_sel_e  src1_sel;
    src2_sel_e  src2_sel;
    wd_sel_e    wd_sel;
    pc_sel_e    pc_sel;
    logic [2:0] br_op;
    logic       branch;
    mem_ctrl_t  mem;
    logic       reg_en;
  } dec_ctrl_t;

  typedef struct packed {
    instr_u     instr;
    word_t      pc;
    word_t      src1;
    word_t      src2;
    word_t      store_data;
    reg_idx_t   rd;
    word_t      imm;
    word_t      pc_next;
    alu_op_e    alu_op;
    wd_sel_e    wd_sel;
    pc_sel_e    pc_sel;
    logic [2:0] br_op;
    logic       branch;
    mem_ctrl_t  mem;
    logic       reg_en;
  } issue_t;

  typedef struct packed {
    logic  busy;
    logic  starting;
    logic  writes_reg;
    word_t result;
  } exu_status_t;

  typedef struct packed {
    logic     busy;
    reg_idx_t rd;
  } lsu_status_t;

  typedef struct packed {
    logic     reg_valid;
    reg_idx_t rd;
    word_t    wd;
  } wbu_status_t;

endpackage

//--- verilog/idu_decoder.sv
// RV32I instruction decoder: format, register indices, immediate and control bundle
`timescale 1ns/1ps

module idu_decoder import rv_isa_pkg::*, idu_ctrl_pkg::*; (
  input  instr_u     instr_i,
  output instr_fmt_e fmt_o,
  output reg_idx_t   rs1_o,
  output reg_idx_t   rs2_o,
  output reg_idx_t   rd_o,
  output word_t      imm_o,
  output dec_ctrl_t  ctrl_o
);

  logic [2:0] funct3;
  logic       alt;

  assign funct3 = instr_i.r.funct3;
  // instr[30], selects sub and sra
  assign alt    = instr_i.r.funct7[5];

  function automatic alu_op_e alu_from_f3(logic [2:0] f3, logic sub, logic sra);
    case (f3)
      F3_ADD_SUB: alu_from_f3 = sub ? ALU_SUB : ALU_ADD;
      F3_SLL:     alu_from_f3 = ALU_SLL;
      F3_SLT:     alu_from_f3 = ALU_SLT;
      F3_SLTU:    alu_from_f3 = ALU_SLTU;
      F3_XOR:     alu_from_f3 = ALU_XOR;
      F3_SRL_SRA: alu_from_f3 = sra ? ALU_SRA : ALU_SRL;
      F3_OR:      alu_from_f3 = ALU_OR;
      F3_AND:     alu_from_f3 = ALU_AND;
      default:    alu_from_f3 = ALU_ADD;
    endcase
  endfunction

  always_comb begin
    case (instr_i.r.opcode)
      OP_OP:                   fmt_o = FMT_R;
      OP_IMM, OP_LOAD, OP_JALR: fmt_o = FMT_I;
      OP_STORE:                fmt_o = FMT_S;
      OP_BRANCH:               fmt_o = FMT_B;
      OP_LUI, OP_AUIPC:        fmt_o = FMT_U;
      OP_JAL:                  fmt_o = FMT_J;
      default:                 fmt_o = FMT_ILLEGAL;
    endcase
  end

  // unused index fields read as x0 so they never stall or forward
  always_comb begin
    imm_o = '0;
    rs1_o = '0;
    rs2_o = '0;
    rd_o  = '0;
    case (fmt_o)
      FMT_R: begin
        rs1_o = instr_i.r.rs1;
        rs2_o = instr_i.r.rs2;
        rd_o  = instr_i.r.rd;
      end
      FMT_I: begin
        imm_o = {{20{instr_i.i.imm_11_0[11]}}, instr_i.i.imm_11_0};
        rs1_o = instr_i.i.rs1;
        rd_o  = instr_i.i.rd;
      end
      FMT_S: begin
        imm_o = {{20{instr_i.s.imm_11_5[6]}}, instr_i.s.imm_11_5, instr_i.s.imm_4_0};
        rs1_o = instr_i.s.rs1;
        rs2_o = instr_i.s.rs2;
      end
      FMT_B: begin
        imm_o = {{20{instr_i.b.imm_12}}, instr_i.b.imm_11, instr_i.b.imm_10_5,
                 instr_i.b.imm_4_1, 1'b0};
        rs1_o = instr_i.b.rs1;
        rs2_o = instr_i.b.rs2;
      end
      FMT_U: begin
        imm_o = {instr_i.u.imm_31_12, 12'b0};
        rd_o  = instr_i.u.rd;
      end
      FMT_J: begin
        imm_o = {{12{instr_i.j.imm_20}}, instr_i.j.imm_19_12, instr_i.j.imm_11,
                 instr_i.j.imm_10_1, 1'b0};
        rd_o  = instr_i.j.rd;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    ctrl_o          = '0;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.src1_sel = SRC1_REG;
    ctrl_o.src2_sel = (fmt_o == FMT_R || fmt_o == FMT_B) ? SRC2_REG : SRC2_IMM;
    ctrl_o.wd_sel   = WD_ALU;
    ctrl_o.pc_sel   = PC_SEQ;
    ctrl_o.reg_en   = fmt_o inside {FMT_R, FMT_I, FMT_U, FMT_J};
    case (instr_i.r.opcode)
      OP_LUI:   ctrl_o.alu_op = ALU_IMM;
      OP_AUIPC: ctrl_o.src1_sel = SRC1_PC;
      OP_JAL: begin
        ctrl_o.src1_sel = SRC1_PC;
        ctrl_o.wd_sel   = WD_PC4;
        ctrl_o.pc_sel   = PC_REL;
      end
      OP_JALR: begin
        ctrl_o.wd_sel = WD_PC4;
        ctrl_o.pc_sel = PC_REG;
      end
      OP_BRANCH: begin
        ctrl_o.branch = 1'b1;
        ctrl_o.br_op  = funct3;
        ctrl_o.pc_sel = PC_REL;
        case (funct3)
          F3_BEQ, F3_BNE: ctrl_o.alu_op = ALU_SUB;
          F3_BLT, F3_BGE: ctrl_o.alu_op = ALU_SLT;
          default:        ctrl_o.alu_op = ALU_SLTU;
        endcase
      end
      OP_LOAD: begin
        ctrl_o.mem.ren = 1'b1;
        ctrl_o.wd_sel  = WD_LOAD;
        case (funct3)
          F3_B:  {ctrl_o.mem.rmask, ctrl_o.mem.sign} = {32'h0000_00ff, 1'b1};
          F3_H:  {ctrl_o.mem.rmask, ctrl_o.mem.sign} = {32'h0000_ffff, 1'b1};
          F3_W:  ctrl_o.mem.rmask = 32'hffff_ffff;
          F3_BU: ctrl_o.mem.rmask = 32'h0000_00ff;
          F3_HU: ctrl_o.mem.rmask = 32'h0000_ffff;
          default: begin
          end
        endcase
      end
      OP_STORE: begin
        ctrl_o.mem.wen = 1'b1;
        case (funct3)
          F3_B:    ctrl_o.mem.wmask = 8'h01;
          F3_H:    ctrl_o.mem.wmask = 8'h03;
          F3_W:    ctrl_o.mem.wmask = 8'h0f;
          default: ctrl_o.mem.wmask = 8'h00;
        endcase
      end
      OP_IMM:  ctrl_o.alu_op = alu_from_f3(funct3, 1'b0, alt);
      OP_OP:   ctrl_o.alu_op = alu_from_f3(funct3, alt, alt);
      default: begin
      end
    endcase
  end

endmodule

//--- verilog/idu_hazard_fwd.sv
// operand hazard unit: forwarding from execute and write-back, load/execute stall detect
`timescale 1ns/1ps

module idu_hazard_fwd import rv_isa_pkg::*, idu_ctrl_pkg::*; (
  input  reg_idx_t    rs1_i,
  input  reg_idx_t    rs2_i,
  input  dec_ctrl_t   ctrl_i,
  input  word_t       pc_i,
  input  word_t       imm_i,
  input  word_t       rs1_data_i,
  input  word_t       rs2_data_i,
  input  exu_status_t exu_i,
  input  reg_idx_t    issued_rd_i,
  input  lsu_status_t lsu_i,
  input  wbu_status_t wbu_i,
  output word_t       src1_o,
  output word_t       src2_o,
  output word_t       store_data_o,
  output logic        conflict_o
);

  word_t fwd1;
  word_t fwd2;
  logic  exu_conflict;
  logic  lsu_conflict;

  // execute holds the newest value, then write-back, then the register file
  function automatic word_t forward(reg_idx_t idx, word_t rf_data, exu_status_t exu,
                                    reg_idx_t exu_rd, wbu_status_t wbu);
    forward = rf_data;
    if (idx != '0) begin
      if (exu.busy && exu.writes_reg && idx == exu_rd)
        forward = exu.result;
      else if (wbu.reg_valid && idx == wbu.rd)
        forward = wbu.wd;
    end
  endfunction

  function automatic logic src_hit(reg_idx_t a, reg_idx_t b, reg_idx_t rd);
    return (rd != '0) && (a == rd || b == rd);
  endfunction

  assign fwd1 = forward(rs1_i, rs1_data_i, exu_i, issued_rd_i, wbu_i);
  assign fwd2 = forward(rs2_i, rs2_data_i, exu_i, issued_rd_i, wbu_i);

  assign src1_o       = (ctrl_i.src1_sel == SRC1_PC) ? pc_i : fwd1;
  assign src2_o       = (ctrl_i.src2_sel == SRC2_IMM) ? imm_i : fwd2;
  assign store_data_o = fwd2;

  // result not ready while execute starts or a load is in flight
  assign exu_conflict = exu_i.starting && exu_i.writes_reg &&
                        src_hit(rs1_i, rs2_i, issued_rd_i);
  assign lsu_conflict = lsu_i.busy && src_hit(rs1_i, rs2_i, lsu_i.rd);

  assign conflict_o = exu_conflict || lsu_conflict;

endmodule

//--- verilog/idu_issue_ctrl.sv
// issue control: decode FSM, one-entry skid buffer and the issue register
`timescale 1ns/1ps

module idu_issue_ctrl import rv_isa_pkg::*, idu_ctrl_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  instr_u instr_i,
  input  word_t  pc_i,
  input  logic   in_valid_i,
  output logic   in_ready_o,
  input  logic   out_ready_i,
  input  logic   conflict_i,
  input  issue_t next_i,
  output instr_u cur_instr_o,
  output word_t  cur_pc_o,
  output logic   out_valid_o,
  output issue_t issue_o,
  output logic   pc_write_o
);

  typedef enum logic {S_IDLE, S_DECODE} state_e;

  state_e state_q;
  state_e state_d;
  logic   buf_full_q;
  logic   buf_we;
  instr_u buf_instr_q;
  word_t  buf_pc_q;
  instr_u held_instr_q;
  word_t  held_pc_q;
  logic   out_valid_q;
  logic   load;
  issue_t issue_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:   if (in_valid_i || buf_full_q) state_d = S_DECODE;
      S_DECODE: if (out_valid_q && out_ready_i) state_d = S_IDLE;
      default:  state_d = S_IDLE;
    endcase
  end

  // arrival while a result still waits goes to the buffer
  assign buf_we = !buf_full_q && in_valid_i && out_valid_q;
  assign load   = (state_d == S_DECODE) && !out_valid_q && !conflict_i;

  assign cur_instr_o = buf_full_q ? buf_instr_q : (in_valid_i ? instr_i : held_instr_q);
  assign cur_pc_o    = buf_full_q ? buf_pc_q : (in_valid_i ? pc_i : held_pc_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_IDLE;
      buf_full_q  <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (load)
        out_valid_q <= 1'b1;
      else if (state_d == S_IDLE)
        out_valid_q <= 1'b0;
      if (buf_we)
        buf_full_q <= 1'b1;
      else if (load)
        buf_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (buf_we) begin
      buf_instr_q <= instr_i;
      buf_pc_q    <= pc_i;
    end
    // keeps the instruction across stall cycles
    if (state_d == S_DECODE) begin
      held_instr_q <= cur_instr_o;
      held_pc_q    <= cur_pc_o;
    end
    if (load)
      issue_q <= next_i;
  end

  assign in_ready_o  = !buf_full_q;
  assign out_valid_o = out_valid_q;
  assign issue_o     = issue_q;
  assign pc_write_o  = out_valid_q && out_ready_i;

endmodule

//--- verilog/idu_top.sv
// decode stage top: issue control, decoder, hazard/forwarding and branch unit
`timescale 1ns/1ps

module idu_top import rv_isa_pkg::*, idu_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  instr_u      instr_i,
  input  word_t       pc_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  output reg_idx_t    rs1_o,
  output reg_idx_t    rs2_o,
  input  word_t       rs1_data_i,
  input  word_t       rs2_data_i,
  input  exu_status_t exu_i,
  input  lsu_status_t lsu_i,
  input  wbu_status_t wbu_i,
  output logic        out_valid_o,
  input  logic        out_ready_i,
  output issue_t      issue_o,
  output logic        pc_write_o
);

  instr_u    cur_instr;
  word_t     cur_pc;
  reg_idx_t  rd;
  word_t     imm;
  dec_ctrl_t ctrl;
  word_t     src1;
  word_t     src2;
  word_t     store_data;
  word_t     pc_next;
  logic      conflict;
  issue_t    next;

  idu_issue_ctrl u_issue_ctrl (
    .clk         (clk),
    .rst         (rst),
    .instr_i     (instr_i),
    .pc_i        (pc_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .out_ready_i (out_ready_i),
    .conflict_i  (conflict),
    .next_i      (next),
    .cur_instr_o (cur_instr),
    .cur_pc_o    (cur_pc),
    .out_valid_o (out_valid_o),
    .issue_o     (issue_o),
    .pc_write_o  (pc_write_o)
  );

  idu_decoder u_decoder (
    .instr_i (cur_instr),
    .fmt_o   (),
    .rs1_o   (rs1_o),
    .rs2_o   (rs2_o),
    .rd_o    (rd),
    .imm_o   (imm),
    .ctrl_o  (ctrl)
  );

  // the bundle in the issue register is the one in execute
  idu_hazard_fwd u_hazard_fwd (
    .rs1_i        (rs1_o),
    .rs2_i        (rs2_o),
    .ctrl_i       (ctrl),
    .pc_i         (cur_pc),
    .imm_i        (imm),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .exu_i        (exu_i),
    .issued_rd_i  (issue_o.rd),
    .lsu_i        (lsu_i),
    .wbu_i        (wbu_i),
    .src1_o       (src1),
    .src2_o       (src2),
    .store_data_o (store_data),
    .conflict_o   (conflict)
  );

  idu_branch_unit u_branch_unit (
    .pc_i      (cur_pc),
    .imm_i     (imm),
    .src1_i    (src1),
    .src2_i    (src2),
    .ctrl_i    (ctrl),
    .pc_next_o (pc_next)
  );

  always_comb begin
    next.instr      = cur_instr;
    next.pc         = cur_pc;
    next.src1       = src1;
    next.src2       = src2;
    next.store_data = store_data;
    next.rd         = rd;
    next.imm        = imm;
    next.pc_next    = pc_next;
    next.alu_op     = ctrl.alu_op;
    next.wd_sel     = ctrl.wd_sel;
    next.pc_sel     = ctrl.pc_sel;
    next.br_op      = ctrl.br_op;
    next.branch     = ctrl.branch;
    next.mem        = ctrl.mem;
    next.reg_en     = ctrl.reg_en;
  end

endmodule

//--- verilog/rv_isa_pkg.sv
// RV32I ISA package: opcodes, funct3 codes, formats and the instruction word views
package rv_isa_pkg;

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [XLEN-1:0]      word_t;

  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_OP     = 7'b0110011
  } opcode_e;

  // integer ops
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // load/store widths
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_ILLEGAL
  } instr_fmt_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one word, read through the view of its format
  typedef union packed {
    logic [31:0] word;
    r_fmt_t      r;
    i_fmt_t      i;
    s_fmt_t      s;
    b_fmt_t      b;
    u_fmt_t      u;
    j_fmt_t      j;
  } instr_u;

endpackage
